// File: compile.f
+incdir+include
verilog/alu_op_pkg.sv
verilog/alu_flow_pkg.sv
verilog/alu_decode.sv
verilog/logic_unit.sv
verilog/arith_unit.sv
verilog/alu_result.sv
verilog/alu_top.sv
verification/tb_alu_top.sv

// File: include/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Operand and result width in bits
`define ALU_DATA_WIDTH 32

// Result queue entries
// Upstream owns this many input credits after reset
`define ALU_RESULT_DEPTH 4

// Credits held toward downstream after reset
`define ALU_OUT_CREDITS 2

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_alu_top \
    -Mdir obj_dir -o sim_alu

./obj_dir/sim_alu | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"

// File: verification/tb_alu_top.sv
`include "alu_settings.svh"

module tb_alu_top import alu_op_pkg::*, alu_flow_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW = `ALU_DATA_WIDTH;
    localparam int SHAMT_W = $clog2(DW);
    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] SEED = 32'he607_a303;

    logic soc_clk;
    logic reset;
    logic in_valid;
    alu_opcode_e in_opcode;
    logic [DW-1:0] in_operand_a;
    logic [DW-1:0] in_operand_b;
    logic in_credit;
    logic out_valid;
    logic [DW-1:0] out_result;
    logic out_illegal;
    logic out_credit;

    // Expected {illegal, result} in issue order
    logic [DW:0] exp_q[$];
    logic [DW:0] exp_head;

    // Credits held by the testbench as upstream
    credit_count_t up_credits;
    // Results received but not yet credited back downstream
    credit_count_t down_owed;
    // 0 hold, 1 random, 2 steady
    int credit_mode;
    logic credit_give;

    logic [31:0] stim_state;
    logic [31:0] credit_state;

    int errors;
    int out_count;
    int in_credit_count;
    int returned_count;
    int sent_count;
    int tests_run;
    int tests_failed;
    int test_err_base;
    string test_name;

    alu_top u_alu_top (
        .soc_clk      (soc_clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_opcode    (in_opcode),
        .in_operand_a (in_operand_a),
        .in_operand_b (in_operand_b),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_result   (out_result),
        .out_illegal  (out_illegal),
        .out_credit   (out_credit)
    );

    // 4 ns period
    initial soc_clk = 1'b0;
    always #2 soc_clk = ~soc_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    // Expected result straight from the opcode table
    function automatic logic [DW:0] model_result(input logic [4:0] op,
                                                 input logic [DW-1:0] a,
                                                 input logic [DW-1:0] b);
        logic [DW-1:0] r;
        logic [SHAMT_W-1:0] sh;
        logic [DW-1:0] sign_fill;
        logic lt;
        logic ill;
        sh = b[SHAMT_W-1:0];
        ill = 1'b0;
        lt = 1'b0;
        // Ones shifted in from the left for SRA of a negative value
        sign_fill = a[DW-1] ? ~({DW{1'b1}} >> sh) : '0;
        case (op)
            5'd0: r = a + b;
            5'd1: r = a - b;
            5'd2: begin
                // Flip sign bits to turn a signed compare into unsigned
                lt = ({~a[DW-1], a[DW-2:0]} < {~b[DW-1], b[DW-2:0]});
                r = {{(DW-1){1'b0}}, lt};
            end
            5'd3: begin
                lt = (a < b);
                r = {{(DW-1){1'b0}}, lt};
            end
            5'd4: r = a << sh;
            5'd5: r = a >> sh;
            5'd6: r = (a >> sh) | sign_fill;
            5'd11: r = a ^ b;
            5'd14: r = a | b;
            5'd15: r = a & b;
            default: begin
                r = '0;
                ill = 1'b1;
            end
        endcase
        return {ill, r};
    endfunction

    // Main process always sits 1 ns past a rising edge
    task automatic next_cycle();
        @(posedge soc_clk);
        #1;
    endtask

    task automatic send_op(input logic [4:0] op, input logic [DW-1:0] a,
                           input logic [DW-1:0] b);
        int waited;
        waited = 0;
        while (up_credits == 0 && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (up_credits == 0) begin
            $display("Timeout at %0t: no input credit came back in test %s", $time, test_name);
            errors++;
        end else begin
            in_valid = 1'b1;
            in_opcode = alu_opcode_e'(op);
            in_operand_a = a;
            in_operand_b = b;
            exp_q.push_back(model_result(op, a, b));
            up_credits--;
            sent_count++;
            next_cycle();
            in_valid = 1'b0;
        end
    endtask

    // Until every expected result is out and every credit returned
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || down_owed != 0) && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout at %0t: %0d results never came out in test %s",
                     $time, exp_q.size(), test_name);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_base = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == test_err_base) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed, %0d errors", test_name, errors - test_err_base);
        end
    endtask

    // Downstream side, credits go back a cycle or more after a result
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge soc_clk);
            #1;
            out_credit = 1'b0;
            credit_give = 1'b0;
            if (!reset && down_owed != 0) begin
                if (credit_mode == 2) begin
                    credit_give = 1'b1;
                end else if (credit_mode == 1) begin
                    credit_state = xorshift32(credit_state);
                    credit_give = credit_state[7] & credit_state[19];
                end
            end
            if (credit_give) begin
                out_credit = 1'b1;
                down_owed--;
                returned_count++;
            end
        end
    end

    // Outputs sampled mid-cycle, where they are settled
    always @(negedge soc_clk) begin
        if (!reset) begin
            if (in_credit) begin
                up_credits++;
                in_credit_count++;
            end
            if (out_valid) begin
                out_count++;
                down_owed++;
                assert (exp_q.size() != 0) else begin
                    $display("Result %h came out at %0t with nothing outstanding",
                             out_result, $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_head = exp_q.pop_front();
                    assert (out_result == exp_head[DW-1:0] && out_illegal == exp_head[DW])
                    else begin
                        $display("MISMATCH at %0t: got %h illegal %b, expected %h illegal %b",
                                 $time, out_result, out_illegal, exp_head[DW-1:0],
                                 exp_head[DW]);
                        errors++;
                    end
                end
            end
        end
    end

    // One input credit per popped result, same cycle
    credit_follows_pop: assert property (@(posedge soc_clk) disable iff (reset)
        in_credit == out_valid)
    else begin
        $display("MISMATCH at %0t: in_credit %b but out_valid %b", $time, in_credit, out_valid);
        errors++;
    end

    // Credit seen at this edge only counts from the next one
    // out_count already holds the pop being checked
    pop_within_credit: assert property (@(posedge soc_clk) disable iff (reset)
        out_valid |-> (out_count + int'(out_credit) <= returned_count + `ALU_OUT_CREDITS))
    else begin
        $display("Result sent at %0t without an output credit", $time);
        errors++;
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_opcode = OP_ADD;
        in_operand_a = '0;
        in_operand_b = '0;
        up_credits = credit_count_t'(`ALU_RESULT_DEPTH);
        down_owed = '0;
        credit_mode = 0;
        stim_state = SEED;
        credit_state = xorshift32(SEED);
        errors = 0;
        out_count = 0;
        in_credit_count = 0;
        returned_count = 0;
        sent_count = 0;
        tests_run = 0;
        tests_failed = 0;
        @(posedge soc_clk);
        @(posedge soc_clk);
        #1;
        reset = 1'b0;

        start_test("reset_and_credit_limit");
        for (int i = 0; i < 6; i++) begin
            assert (!out_valid && !in_credit) else begin
                $display("Output activity at %0t with nothing sent", $time);
                errors++;
            end
            next_cycle();
        end
        // Fill every input credit, hold all output credits back
        for (int i = 0; i < `ALU_RESULT_DEPTH; i++) begin
            send_op(5'd11, next_rand(), next_rand());
        end
        for (int i = 0; i < WAIT_LIMIT && out_count < `ALU_OUT_CREDITS; i++) begin
            next_cycle();
        end
        // Quiet window, nothing more may leave
        for (int i = 0; i < 10; i++) begin
            next_cycle();
        end
        assert (out_count == `ALU_OUT_CREDITS) else begin
            $display("MISMATCH at %0t: %0d results with no credit returned, expected %0d",
                     $time, out_count, `ALU_OUT_CREDITS);
            errors++;
        end
        credit_mode = 2;
        wait_drain();
        finish_test();

        start_test("logic_ops");
        for (int i = 0; i < 30; i++) begin
            case (next_rand() % 3)
                0: send_op(5'd11, next_rand(), next_rand());
                1: send_op(5'd14, next_rand(), next_rand());
                default: send_op(5'd15, next_rand(), next_rand());
            endcase
        end
        wait_drain();
        finish_test();

        start_test("arith_ops");
        // Wrap, sign against unsigned, shift amounts past 31
        send_op(5'd0, 32'hffff_ffff, 32'h0000_0001);
        send_op(5'd1, 32'h0000_0000, 32'h0000_0001);
        send_op(5'd2, 32'hffff_ffff, 32'h0000_0001);
        send_op(5'd3, 32'hffff_ffff, 32'h0000_0001);
        send_op(5'd2, 32'h7fff_ffff, 32'h8000_0000);
        send_op(5'd3, 32'h7fff_ffff, 32'h8000_0000);
        send_op(5'd4, 32'h8000_0001, 32'd37);
        send_op(5'd5, 32'h8000_0001, 32'd32);
        send_op(5'd6, 32'h8000_0000, 32'd63);
        send_op(5'd6, 32'h4000_0000, 32'd30);
        for (int i = 0; i < 40; i++) begin
            send_op(5'(next_rand() % 7), next_rand(), next_rand());
        end
        wait_drain();
        finish_test();

        start_test("illegal_ops");
        // Whole code space in order, legal and illegal interleaved
        for (int op = 0; op < 32; op++) begin
            send_op(5'(op), next_rand(), next_rand());
        end
        wait_drain();
        finish_test();

        start_test("backpressure");
        credit_mode = 1;
        for (int i = 0; i < 60; i++) begin
            send_op(5'(next_rand()), next_rand(), next_rand());
        end
        wait_drain();
        assert (in_credit_count == out_count) else begin
            $display("MISMATCH at %0t: %0d input credits for %0d results",
                     $time, in_credit_count, out_count);
            errors++;
        end
        finish_test();

        start_test("back_to_back");
        credit_mode = 2;
        for (int i = 0; i < 40; i++) begin
            send_op(5'(next_rand()), next_rand(), next_rand());
        end
        wait_drain();
        assert (out_count == sent_count && exp_q.size() == 0) else begin
            $display("MISMATCH at %0t: %0d results for %0d operations",
                     $time, out_count, sent_count);
            errors++;
        end
        finish_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verilog/alu_decode.sv
`include "alu_settings.svh"

module alu_decode import alu_op_pkg::*; (
    input  logic                       soc_clk,
    input  logic                       reset,

    // Upstream, credit controlled, no ready
    input  logic                       in_valid,
    input  alu_opcode_e                in_opcode,
    input  logic [`ALU_DATA_WIDTH-1:0] in_operand_a,
    input  logic [`ALU_DATA_WIDTH-1:0] in_operand_b,

    // Issue toward both units
    output logic                       issue_valid,
    output exec_unit_e                 issue_unit,
    output logic_op_e                  issue_logic_op,
    output arith_op_e                  issue_arith_op,
    output logic                       issue_illegal,
    output logic [`ALU_DATA_WIDTH-1:0] issue_operand_a,
    output logic [`ALU_DATA_WIDTH-1:0] issue_operand_b
);

    // Decoded fields of the incoming opcode
    exec_unit_e dec_unit;
    logic_op_e  dec_logic_op;
    arith_op_e  dec_arith_op;
    logic       dec_illegal;

    // Opcode classification
    always_comb begin
        // Defaults describe an illegal code
        // Routed to the logic unit, which clears the result
        dec_unit     = UNIT_LOGIC;
        dec_logic_op = LOGIC_ZERO;
        dec_arith_op = ARITH_ADD;
        dec_illegal  = 1'b1;
        case (in_opcode)
            OP_XOR: begin
                dec_logic_op = LOGIC_XOR;
                dec_illegal  = 1'b0;
            end
            OP_OR: begin
                dec_logic_op = LOGIC_OR;
                dec_illegal  = 1'b0;
            end
            OP_AND: begin
                dec_logic_op = LOGIC_AND;
                dec_illegal  = 1'b0;
            end
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA: begin
                dec_unit    = UNIT_ARITH;
                dec_illegal = 1'b0;
                // Arithmetic sub-op numbering matches the low opcode bits
                dec_arith_op = arith_op_e'(in_opcode[2:0]);
            end
            default: begin
                dec_unit = UNIT_LOGIC;
            end
        endcase
    end

    // Issue strobe, one cycle after in_valid
    always_ff @(posedge soc_clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= in_valid;
        end
    end

    // Operation payload, only loaded on an accepted beat
    always_ff @(posedge soc_clk) begin
        if (in_valid) begin
            issue_unit      <= dec_unit;
            issue_logic_op  <= dec_logic_op;
            issue_arith_op  <= dec_arith_op;
            issue_illegal   <= dec_illegal;
            issue_operand_a <= in_operand_a;
            issue_operand_b <= in_operand_b;
        end
    end

endmodule

// File: verilog/alu_flow_pkg.sv
package alu_flow_pkg;

    `include "alu_settings.svh"

    // Largest credit value either counter has to hold
    localparam int CREDIT_MAX = (`ALU_RESULT_DEPTH > `ALU_OUT_CREDITS) ?
                                `ALU_RESULT_DEPTH : `ALU_OUT_CREDITS;

    // Counter width, must reach CREDIT_MAX itself
    localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

    // Index bits into the result queue
    localparam int QUEUE_IDX_W = $clog2(`ALU_RESULT_DEPTH);

    // Credit counter
    typedef logic [CREDIT_W-1:0] credit_count_t;

    // Queue pointer, MSB is the wrap bit
    typedef logic [QUEUE_IDX_W:0] queue_ptr_t;

endpackage

// File: verilog/alu_op_pkg.sv
package alu_op_pkg;

    // Opcode map as seen on in_opcode
    // Logic codes keep the legacy numbering
    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_SLT  = 5'd2,
        OP_SLTU = 5'd3,
        OP_SLL  = 5'd4,
        OP_SRL  = 5'd5,
        OP_SRA  = 5'd6,
        OP_XOR  = 5'd11,
        OP_OR   = 5'd14,
        OP_AND  = 5'd15
    } alu_opcode_e;

    // Target unit of an issued operation
    typedef enum logic {
        UNIT_ARITH = 1'b0,
        UNIT_LOGIC = 1'b1
    } exec_unit_e;

    // Logic unit operation, ZERO for illegal codes
    typedef enum logic [1:0] {
        LOGIC_XOR  = 2'd0,
        LOGIC_OR   = 2'd1,
        LOGIC_AND  = 2'd2,
        LOGIC_ZERO = 2'd3
    } logic_op_e;

    // Arithmetic unit operation
    typedef enum logic [2:0] {
        ARITH_ADD  = 3'd0,
        ARITH_SUB  = 3'd1,
        ARITH_SLT  = 3'd2,
        ARITH_SLTU = 3'd3,
        ARITH_SLL  = 3'd4,
        ARITH_SRL  = 3'd5,
        ARITH_SRA  = 3'd6
    } arith_op_e;

endpackage

// File: verilog/alu_result.sv
`include "alu_settings.svh"

module alu_result import alu_flow_pkg::*; (
    input  logic                       soc_clk,
    input  logic                       reset,

    // Unit results, at most one valid per cycle
    input  logic                       logic_valid,
    input  logic [`ALU_DATA_WIDTH-1:0] logic_result,
    input  logic                       logic_illegal,
    input  logic                       arith_valid,
    input  logic [`ALU_DATA_WIDTH-1:0] arith_result,

    // Downstream credit return
    input  logic                       out_credit,

    // Downstream result beat
    output logic                       out_valid,
    output logic [`ALU_DATA_WIDTH-1:0] out_result,
    output logic                       out_illegal,

    // Credit back to upstream, one per pop
    output logic                       in_credit
);

    // Queue storage
    logic [`ALU_DATA_WIDTH-1:0] res_mem [`ALU_RESULT_DEPTH];
    logic                       ill_mem [`ALU_RESULT_DEPTH];

    // Pointers with wrap bit
    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;

    // Credits held toward downstream
    credit_count_t out_credits;

    logic                       wr_en;
    logic [`ALU_DATA_WIDTH-1:0] wr_data;
    logic                       wr_illegal;
    logic                       empty;
    logic                       pop;

    // Write side, pick whichever unit fired
    assign wr_en      = logic_valid || arith_valid;
    assign wr_data    = logic_valid ? logic_result : arith_result;
    // Arithmetic results are never illegal
    assign wr_illegal = logic_valid && logic_illegal;

    // Empty when pointers match including the wrap bit
    // Upstream credits keep the queue from overflowing
    assign empty = (wr_ptr == rd_ptr);

    // Pop the head whenever a downstream credit is held
    assign pop = !empty && (out_credits != '0);

    assign out_valid   = pop;
    assign in_credit   = pop;
    // Zero between beats
    assign out_result  = pop ? res_mem[rd_ptr[QUEUE_IDX_W-1:0]] : '0;
    assign out_illegal = pop && ill_mem[rd_ptr[QUEUE_IDX_W-1:0]];

    // Storage write
    always_ff @(posedge soc_clk) begin
        if (wr_en) begin
            res_mem[wr_ptr[QUEUE_IDX_W-1:0]] <= wr_data;
            ill_mem[wr_ptr[QUEUE_IDX_W-1:0]] <= wr_illegal;
        end
    end

    // Pointer update
    always_ff @(posedge soc_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Output credit accounting
    always_ff @(posedge soc_clk) begin
        if (reset) begin
            out_credits <= credit_count_t'(`ALU_OUT_CREDITS);
        end else begin
            case ({out_credit, pop})
                2'b10:   out_credits <= out_credits + 1'b1;
                2'b01:   out_credits <= out_credits - 1'b1;
                // Return and spend cancel out
                default: out_credits <= out_credits;
            endcase
        end
    end

endmodule

// File: verilog/alu_top.sv
`include "alu_settings.svh"

module alu_top import alu_op_pkg::*; (
    input  logic                       soc_clk,
    input  logic                       reset,

    // Upstream operation beat
    input  logic                       in_valid,
    input  alu_opcode_e                in_opcode,
    input  logic [`ALU_DATA_WIDTH-1:0] in_operand_a,
    input  logic [`ALU_DATA_WIDTH-1:0] in_operand_b,
    output logic                       in_credit,

    // Downstream result beat
    output logic                       out_valid,
    output logic [`ALU_DATA_WIDTH-1:0] out_result,
    output logic                       out_illegal,
    input  logic                       out_credit
);

    // Decode to units
    logic                       issue_valid;
    exec_unit_e                 issue_unit;
    logic_op_e                  issue_logic_op;
    arith_op_e                  issue_arith_op;
    logic                       issue_illegal;
    logic [`ALU_DATA_WIDTH-1:0] issue_operand_a;
    logic [`ALU_DATA_WIDTH-1:0] issue_operand_b;

    // Units to result stage
    logic                       logic_valid;
    logic [`ALU_DATA_WIDTH-1:0] logic_result;
    logic                       logic_illegal;
    logic                       arith_valid;
    logic [`ALU_DATA_WIDTH-1:0] arith_result;

    alu_decode u_alu_decode (
        .soc_clk         (soc_clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .in_opcode       (in_opcode),
        .in_operand_a    (in_operand_a),
        .in_operand_b    (in_operand_b),
        .issue_valid     (issue_valid),
        .issue_unit      (issue_unit),
        .issue_logic_op  (issue_logic_op),
        .issue_arith_op  (issue_arith_op),
        .issue_illegal   (issue_illegal),
        .issue_operand_a (issue_operand_a),
        .issue_operand_b (issue_operand_b)
    );

    // Bitwise ops and illegal codes
    logic_unit u_logic_unit (
        .soc_clk         (soc_clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_unit      (issue_unit),
        .issue_logic_op  (issue_logic_op),
        .issue_illegal   (issue_illegal),
        .issue_operand_a (issue_operand_a),
        .issue_operand_b (issue_operand_b),
        .logic_valid     (logic_valid),
        .logic_result    (logic_result),
        .logic_illegal   (logic_illegal)
    );

    // Add, subtract, compares, shifts
    arith_unit u_arith_unit (
        .soc_clk         (soc_clk),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_unit      (issue_unit),
        .issue_arith_op  (issue_arith_op),
        .issue_operand_a (issue_operand_a),
        .issue_operand_b (issue_operand_b),
        .arith_valid     (arith_valid),
        .arith_result    (arith_result)
    );

    // In-order queue and both credit loops
    alu_result u_alu_result (
        .soc_clk       (soc_clk),
        .reset         (reset),
        .logic_valid   (logic_valid),
        .logic_result  (logic_result),
        .logic_illegal (logic_illegal),
        .arith_valid   (arith_valid),
        .arith_result  (arith_result),
        .out_credit    (out_credit),
        .out_valid     (out_valid),
        .out_result    (out_result),
        .out_illegal   (out_illegal),
        .in_credit     (in_credit)
    );

endmodule

// File: verilog/arith_unit.sv
`include "alu_settings.svh"

module arith_unit import alu_op_pkg::*; (
    input  logic                       soc_clk,
    input  logic                       reset,

    // Issue from decode
    input  logic                       issue_valid,
    input  exec_unit_e                 issue_unit,
    input  arith_op_e                  issue_arith_op,
    input  logic [`ALU_DATA_WIDTH-1:0] issue_operand_a,
    input  logic [`ALU_DATA_WIDTH-1:0] issue_operand_b,

    // Result toward the result stage
    output logic                       arith_valid,
    output logic [`ALU_DATA_WIDTH-1:0] arith_result
);

    // Shift amount width, low bits of operand b
    localparam int SHAMT_W = $clog2(`ALU_DATA_WIDTH);

    logic                       take;
    logic [SHAMT_W-1:0]         shamt;
    logic                       lt_signed;
    logic                       lt_unsigned;
    logic [`ALU_DATA_WIDTH-1:0] next_result;

    assign take  = issue_valid && (issue_unit == UNIT_ARITH);
    assign shamt = issue_operand_b[SHAMT_W-1:0];

    // Compares
    assign lt_signed   = $signed(issue_operand_a) < $signed(issue_operand_b);
    assign lt_unsigned = issue_operand_a < issue_operand_b;

    always_comb begin
        case (issue_arith_op)
            // Sum and difference wrap at the data width
            ARITH_ADD:  next_result = issue_operand_a + issue_operand_b;
            ARITH_SUB:  next_result = issue_operand_a - issue_operand_b;
            // Set-less-than gives 1 or 0
            ARITH_SLT:  next_result = {{(`ALU_DATA_WIDTH-1){1'b0}}, lt_signed};
            ARITH_SLTU: next_result = {{(`ALU_DATA_WIDTH-1){1'b0}}, lt_unsigned};
            ARITH_SLL:  next_result = issue_operand_a << shamt;
            ARITH_SRL:  next_result = issue_operand_a >> shamt;
            // Sign bit refills from the left
            ARITH_SRA:  next_result = $signed(issue_operand_a) >>> shamt;
            default:    next_result = '0;
        endcase
    end

    always_ff @(posedge soc_clk) begin
        if (reset) begin
            arith_valid  <= 1'b0;
            arith_result <= '0;
        end else begin
            // One-cycle pulse per operation
            arith_valid <= take;
            if (take) begin
                arith_result <= next_result;
            end
        end
    end

endmodule

// File: verilog/logic_unit.sv
`include "alu_settings.svh"

module logic_unit import alu_op_pkg::*; (
    input  logic                       soc_clk,
    input  logic                       reset,

    // Issue from decode
    input  logic                       issue_valid,
    input  exec_unit_e                 issue_unit,
    input  logic_op_e                  issue_logic_op,
    input  logic                       issue_illegal,
    input  logic [`ALU_DATA_WIDTH-1:0] issue_operand_a,
    input  logic [`ALU_DATA_WIDTH-1:0] issue_operand_b,

    // Result toward the result stage
    output logic                       logic_valid,
    output logic [`ALU_DATA_WIDTH-1:0] logic_result,
    output logic                       logic_illegal
);

    // Operation addressed to this unit
    logic take;

    assign take = issue_valid && (issue_unit == UNIT_LOGIC);

    always_ff @(posedge soc_clk) begin
        if (reset) begin
            logic_valid   <= 1'b0;
            logic_result  <= '0;
            logic_illegal <= 1'b0;
        end else begin
            // One-cycle pulse per operation
            logic_valid <= take;
            // Result held between operations
            if (take) begin
                case (issue_logic_op)
                    LOGIC_XOR: logic_result <= issue_operand_a ^ issue_operand_b;
                    LOGIC_OR:  logic_result <= issue_operand_a | issue_operand_b;
                    LOGIC_AND: logic_result <= issue_operand_a & issue_operand_b;
                    // Illegal opcodes land here
                    default:   logic_result <= '0;
                endcase
                logic_illegal <= issue_illegal;
            end
        end
    end

endmodule
